//--- src/req_buf_pkg.sv
////////////////////////////////////////
// Request buffer package
// Lane count, payload width, per-lane FIFO sizing and the vector
// types shared by the steer stage, the lanes and the arbiter
////////////////////////////////////////

package req_buf_pkg;

    // Number of independent request lanes
    localparam int N_LANES = 4;

    // Bits needed to name one lane
    localparam int LANE_IDX_BITS = 2;

    // Width of one request payload
    localparam int REQ_DATA_BITS = 32;

    // Entries in the base queue of each lane
    // The output register of a lane adds one more slot on top of these
    localparam int LANE_DEPTH = 8;

    // A lane reports almost-full once this many base slots or fewer are free
    // Two slots cover the request sitting in the steer register plus one
    // more that the source may already have issued
    localparam int LANE_THRESHOLD = 2;

    // A lane number, as carried with each request
    typedef logic [LANE_IDX_BITS-1:0] t_lane_idx;

    // One request payload
    typedef logic [REQ_DATA_BITS-1:0] t_req_data;

    // One bit per lane, used for enables and for status flags
    typedef logic [N_LANES-1:0] t_lane_mask;

endpackage

//--- src/fifo_lutram_base.sv
////////////////////////////////////////
// LUT-RAM FIFO base
// Circular queue in distributed RAM with a live-entry counter and
// registered not_full, almost_full and not_empty flags
////////////////////////////////////////

`timescale 1ns/1ps

module fifo_lutram_base
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = 2,
    parameter int THRESHOLD   = 1
)
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    output logic                   not_full,
    output logic                   almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    // Index into the storage array
    typedef logic [$clog2(N_ENTRIES)-1:0] t_idx;

    // Live-entry count, wide enough to hold both 0 and N_ENTRIES
    typedef logic [$clog2(N_ENTRIES+1)-1:0] t_counter;

    // Storage is small and read asynchronously, so it maps to LUT RAM
    logic [N_DATA_BITS-1:0] data [0:N_ENTRIES-1];

    t_idx     wr_idx;
    t_idx     rd_idx;
    t_counter valid_cnt;
    t_counter valid_cnt_next;

    // The head of the queue is always visible at the read index
    assign first = data[rd_idx];

    // Payload write, no reset needed on the array itself
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            data[wr_idx] <= enq_data;
        end
    end

    // Write index moves on every enq and wraps at the last entry
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_idx <= '0;
        end
        else if (enq_en)
        begin
            wr_idx <= (wr_idx == t_idx'(N_ENTRIES-1)) ? '0 : wr_idx + t_idx'(1);
        end
    end

    // Read index moves on every deq and wraps the same way
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_idx <= '0;
        end
        else if (deq_en)
        begin
            rd_idx <= (rd_idx == t_idx'(N_ENTRIES-1)) ? '0 : rd_idx + t_idx'(1);
        end
    end

    // Next count, unchanged when enq and deq happen together
    always_comb
    begin
        valid_cnt_next = valid_cnt;
        if (enq_en && !deq_en)
        begin
            valid_cnt_next = valid_cnt + t_counter'(1);
        end
        else if (deq_en && !enq_en)
        begin
            valid_cnt_next = valid_cnt - t_counter'(1);
        end
    end

    // Flags come from the next count so they are exact one cycle after a change
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_cnt   <= '0;
            not_full    <= 1'b1;
            almost_full <= 1'b0;
            not_empty   <= 1'b0;
        end
        else
        begin
            valid_cnt   <= valid_cnt_next;
            not_full    <= (valid_cnt_next != t_counter'(N_ENTRIES));
            almost_full <= (valid_cnt_next >= t_counter'(N_ENTRIES - THRESHOLD));
            not_empty   <= (valid_cnt_next != t_counter'(0));
        end
    end

endmodule

//--- src/fifo_lutram.sv
////////////////////////////////////////
// LUT-RAM FIFO
// Base queue with an optional output register in front of first
////////////////////////////////////////

`timescale 1ns/1ps

module fifo_lutram
#(
    parameter int N_DATA_BITS     = 32,
    parameter int N_ENTRIES       = 2,
    parameter int THRESHOLD       = 1,
    // Nonzero adds a registered output stage
    parameter int REGISTER_OUTPUT = 0
)
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    output logic                   not_full,
    output logic                   almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    logic                   base_deq;
    logic                   base_not_empty;
    logic [N_DATA_BITS-1:0] base_first;

    // Full and almost-full always describe the base queue only
    fifo_lutram_base
    #(
        .N_DATA_BITS (N_DATA_BITS),
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    )
    base
    (
        .clk         (clk),
        .reset       (reset),
        .enq_data    (enq_data),
        .enq_en      (enq_en),
        .not_full    (not_full),
        .almost_full (almost_full),
        .first       (base_first),
        .deq_en      (base_deq),
        .not_empty   (base_not_empty)
    );

    generate
        if (REGISTER_OUTPUT == 0)
        begin : g_direct
            // Head of the base queue goes straight out
            assign first     = base_first;
            assign not_empty = base_not_empty;
            assign base_deq  = deq_en;
        end
        else
        begin : g_registered
            logic [N_DATA_BITS-1:0] out_reg;
            logic                   out_valid;

            assign first     = out_reg;
            assign not_empty = out_valid;

            // Pull from the base whenever the register is free or being emptied
            assign base_deq = base_not_empty && (deq_en || !out_valid);

            always_ff @(posedge clk)
            begin
                if (reset)
                begin
                    out_valid <= 1'b0;
                end
                else if (deq_en || !out_valid)
                begin
                    out_valid <= base_not_empty;
                end
            end

            // Payload only, loaded under the same condition as the valid bit
            always_ff @(posedge clk)
            begin
                if (deq_en || !out_valid)
                begin
                    out_reg <= base_first;
                end
            end
        end
    endgenerate

endmodule

//--- src/req_steer.sv
////////////////////////////////////////
// Request steer stage
// Registers each request, decodes its lane to a one-hot enq and
// flags a write to a full lane with a sticky error
////////////////////////////////////////

`timescale 1ns/1ps

module req_steer
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    in_en,
    input  req_buf_pkg::t_lane_idx  in_lane,
    input  req_buf_pkg::t_req_data  in_data,

    input  req_buf_pkg::t_lane_mask lane_not_full,
    output req_buf_pkg::t_lane_mask lane_enq_en,
    output req_buf_pkg::t_req_data  lane_enq_data,

    output logic                    overflow_err
);

    import req_buf_pkg::*;

    logic       req_valid;
    t_lane_idx  req_lane;
    t_req_data  req_data;
    t_lane_mask req_onehot;
    logic       req_blocked;

    // Request register, only the valid bit is control state
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_valid <= 1'b0;
        end
        else
        begin
            req_valid <= in_en;
        end
    end

    always_ff @(posedge clk)
    begin
        req_lane <= in_lane;
        req_data <= in_data;
    end

    // Lane number to one-hot, zero when nothing is held
    assign req_onehot = req_valid ? (t_lane_mask'(1) << req_lane) : '0;

    // A held request that meets a full lane is dropped and counted as an error
    assign req_blocked   = |(req_onehot & ~lane_not_full);
    assign lane_enq_en   = req_onehot & lane_not_full;
    assign lane_enq_data = req_data;

    // Error stays set until reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            overflow_err <= 1'b0;
        end
        else if (req_blocked)
        begin
            overflow_err <= 1'b1;
        end
    end

endmodule

//--- src/req_arbiter.sv
////////////////////////////////////////
// Round-robin lane arbiter
// Drains one not-empty lane per cycle toward a single output port
// and holds off while downstream reports almost-full
////////////////////////////////////////

`timescale 1ns/1ps

module req_arbiter
(
    input  logic                                           clk,
    input  logic                                           reset,

    input  req_buf_pkg::t_lane_mask                        lane_not_empty,
    input  req_buf_pkg::t_req_data [req_buf_pkg::N_LANES-1:0] lane_first,
    input  logic                                           out_almost_full,

    output req_buf_pkg::t_lane_mask                        lane_deq_en,

    output logic                                           out_en,
    output req_buf_pkg::t_lane_idx                         out_lane,
    output req_buf_pkg::t_req_data                         out_data
);

    import req_buf_pkg::*;

    // Lane that won the most recent grant
    t_lane_idx last_grant;
    logic      grant_valid;
    t_lane_idx grant_lane;

    // Search starts one past the last winner and wraps once around all lanes
    always_comb
    begin
        grant_valid = 1'b0;
        grant_lane  = last_grant;
        if (!out_almost_full)
        begin
            for (int i = 1; i <= N_LANES; i++)
            begin
                if (!grant_valid && lane_not_empty[(int'(last_grant) + i) % N_LANES])
                begin
                    grant_valid = 1'b1;
                    grant_lane  = t_lane_idx'((int'(last_grant) + i) % N_LANES);
                end
            end
        end
    end

    // Deq goes out in the same cycle as the decision
    assign lane_deq_en = grant_valid ? (t_lane_mask'(1) << grant_lane) : '0;

    // Pointer starts on the last lane so lane 0 is served first after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last_grant <= t_lane_idx'(N_LANES - 1);
            out_en     <= 1'b0;
        end
        else
        begin
            out_en <= grant_valid;
            if (grant_valid)
            begin
                last_grant <= grant_lane;
            end
        end
    end

    // Output payload, qualified by out_en
    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            out_lane <= grant_lane;
            out_data <= lane_first[grant_lane];
        end
    end

endmodule

//--- src/req_buf_top.sv
////////////////////////////////////////
// Four-lane request buffer
// Steer stage into per-lane LUT-RAM FIFOs, drained by a
// round-robin arbiter toward one output port
////////////////////////////////////////

`timescale 1ns/1ps

module req_buf_top
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    in_en,
    input  req_buf_pkg::t_lane_idx  in_lane,
    input  req_buf_pkg::t_req_data  in_data,
    output req_buf_pkg::t_lane_mask in_almost_full,
    output logic                    overflow_err,

    input  logic                    out_almost_full,
    output logic                    out_en,
    output req_buf_pkg::t_lane_idx  out_lane,
    output req_buf_pkg::t_req_data  out_data
);

    import req_buf_pkg::*;

    t_lane_mask                lane_enq_en;
    t_req_data                 lane_enq_data;
    t_lane_mask                lane_not_full;
    t_lane_mask                lane_not_empty;
    t_lane_mask                lane_deq_en;
    t_req_data [N_LANES-1:0]   lane_first;

    req_steer steer
    (
        .clk           (clk),
        .reset         (reset),
        .in_en         (in_en),
        .in_lane       (in_lane),
        .in_data       (in_data),
        .lane_not_full (lane_not_full),
        .lane_enq_en   (lane_enq_en),
        .lane_enq_data (lane_enq_data),
        .overflow_err  (overflow_err)
    );

    // One queue per lane, all fed from the shared steer data
    // Each lane's almost-full goes straight back to the source
    for (genvar i = 0; i < N_LANES; i++)
    begin : g_lane
        fifo_lutram
        #(
            .N_DATA_BITS     (REQ_DATA_BITS),
            .N_ENTRIES       (LANE_DEPTH),
            .THRESHOLD       (LANE_THRESHOLD),
            .REGISTER_OUTPUT (1)
        )
        lane_fifo
        (
            .clk         (clk),
            .reset       (reset),
            .enq_data    (lane_enq_data),
            .enq_en      (lane_enq_en[i]),
            .not_full    (lane_not_full[i]),
            .almost_full (in_almost_full[i]),
            .first       (lane_first[i]),
            .deq_en      (lane_deq_en[i]),
            .not_empty   (lane_not_empty[i])
        );
    end

    req_arbiter arbiter
    (
        .clk             (clk),
        .reset           (reset),
        .lane_not_empty  (lane_not_empty),
        .lane_first      (lane_first),
        .out_almost_full (out_almost_full),
        .lane_deq_en     (lane_deq_en),
        .out_en          (out_en),
        .out_lane        (out_lane),
        .out_data        (out_data)
    );

endmodule

//--- verification/req_buf_props.sv
////////////////////////////////////////
// Queue protocol properties
// Bound to the arbiter and to every base FIFO
////////////////////////////////////////

`timescale 1ns/1ps

module req_buf_props
#(
    parameter int N_PORTS   = 1,
    // Zero where the bound block has no enq side
    parameter bit CHECK_ENQ = 1'b1
)
(
    input logic               clk,
    input logic               reset,
    input logic [N_PORTS-1:0] enq_en,
    input logic [N_PORTS-1:0] not_full,
    input logic [N_PORTS-1:0] deq_en,
    input logic [N_PORTS-1:0] not_empty
);

    // A deq only ever targets a queue that holds data
    deq_not_empty: assert property (@(posedge clk) disable iff (reset)
        (deq_en & ~not_empty) == '0)
        else $error("deq issued to an empty queue");

    // An enq never lands in a full queue
    if (CHECK_ENQ)
    begin : g_enq
        enq_not_full: assert property (@(posedge clk) disable iff (reset)
            (enq_en & ~not_full) == '0)
            else $error("enq issued to a full queue");
    end

    // At most one of several queues is drained per cycle
    if (N_PORTS > 1)
    begin : g_onehot
        deq_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(deq_en))
            else $error("more than one deq in a cycle");
    end

endmodule

// The arbiter only drains lanes, so its checks cover the deq side
bind req_arbiter req_buf_props
#(
    .N_PORTS   (req_buf_pkg::N_LANES),
    .CHECK_ENQ (1'b0)
)
arbiter_props
(
    .clk       (clk),
    .reset     (reset),
    .enq_en    (),
    .not_full  (),
    .deq_en    (lane_deq_en),
    .not_empty (lane_not_empty)
);

bind fifo_lutram_base req_buf_props #(.N_PORTS(1)) base_props
(
    .clk       (clk),
    .reset     (reset),
    .enq_en    (enq_en),
    .not_full  (not_full),
    .deq_en    (deq_en),
    .not_empty (not_empty)
);

//--- verification/req_buf_tb.sv
////////////////////////////////////////
// Request buffer testbench
// Replays a command trace into the four-lane buffer and checks
// every output against per-lane expected queues
////////////////////////////////////////

`timescale 1ns/1ps

module req_buf_tb;

    import req_buf_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    // Cycle limits for the two kinds of wait
    localparam int ISSUE_LIMIT  = 200;
    localparam int DRAIN_LIMIT  = 2000;

    logic       clk;
    logic       reset;
    logic       in_en;
    t_lane_idx  in_lane;
    t_req_data  in_data;
    t_lane_mask in_almost_full;
    logic       overflow_err;
    logic       out_almost_full;
    logic       out_en;
    t_lane_idx  out_lane;
    t_req_data  out_data;

    // Expected payloads per lane in issue order
    t_req_data  exp_q [N_LANES][$];
    int         issued_cnt;
    int         out_cnt;
    int         stall_out_cnt;
    logic       rr_check;
    logic       rr_have_prev;
    t_lane_idx  rr_prev_lane;

    req_buf_top uut
    (
        .clk             (clk),
        .reset           (reset),
        .in_en           (in_en),
        .in_lane         (in_lane),
        .in_data         (in_data),
        .in_almost_full  (in_almost_full),
        .overflow_err    (overflow_err),
        .out_almost_full (out_almost_full),
        .out_en          (out_en),
        .out_lane        (out_lane),
        .out_data        (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected)
        begin
            $display("[FAIL] %0d ns: %s, expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0d ns: %s", $time, why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped on a run error");
    endtask

    function automatic int pending_count();
        int total;
        total = 0;
        for (int l = 0; l < N_LANES; l++)
        begin
            total += exp_q[l].size();
        end
        return total;
    endfunction

    // Source side honours the lane's almost-full level before each request
    task automatic issue_request(input t_lane_idx lane, input t_req_data data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (in_almost_full[lane])
        begin
            if (waited >= ISSUE_LIMIT)
            begin
                abort_run($sformatf("lane %0d stayed almost-full too long", lane));
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        in_en   <= 1'b1;
        in_lane <= lane;
        in_data <= data;
        exp_q[lane].push_back(data);
        issued_cnt++;
        @(posedge clk);
        in_en <= 1'b0;
    endtask

    task automatic set_stall(input logic level);
        @(posedge clk);
        // A fresh rise restarts the count of trailing outputs
        if (level && !out_almost_full)
        begin
            stall_out_cnt = 0;
        end
        out_almost_full <= level;
    endtask

    task automatic drain_lanes();
        int waited;
        waited = 0;
        @(posedge clk);
        while (pending_count() != 0)
        begin
            if (waited >= DRAIN_LIMIT)
            begin
                abort_run("lanes did not drain before the timeout");
            end
            waited++;
            @(posedge clk);
        end
    endtask

    // Output monitor samples at the falling edge where registered outputs are settled
    always @(negedge clk)
    begin
        if (!reset && out_en)
        begin
            out_cnt++;
            if (out_almost_full)
            begin
                stall_out_cnt++;
                if (stall_out_cnt > 1)
                begin
                    abort_run("more than one output followed the rise of the stall");
                end
            end
            if (exp_q[out_lane].size() == 0)
            begin
                abort_run($sformatf("output on lane %0d with nothing pending", out_lane));
            end
            else
            begin
                compare(out_data, exp_q[out_lane].pop_front(),
                        $sformatf("data on lane %0d", out_lane));
            end
            // With all lanes backlogged each grant moves to the next lane
            if (rr_check && rr_have_prev)
            begin
                compare(32'(out_lane), 32'((int'(rr_prev_lane) + 1) % N_LANES),
                        "round-robin lane order");
            end
            rr_prev_lane = out_lane;
            rr_have_prev = 1'b1;
        end
    end

    initial
    begin
        int          fd;
        int          n;
        int          ch;
        int unsigned gap;
        logic [7:0]  cmd;
        logic [31:0] arg_a;
        logic [31:0] arg_b;

        reset           = 1'b1;
        in_en           = 1'b0;
        in_lane         = '0;
        in_data         = '0;
        out_almost_full = 1'b0;
        issued_cnt      = 0;
        out_cnt         = 0;
        stall_out_cnt   = 0;
        rr_check        = 1'b0;
        rr_have_prev    = 1'b0;
        rr_prev_lane    = '0;
        gap             = $urandom(32'h6ef0);

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Outputs stay quiet until the first request
        repeat (3)
        begin
            @(negedge clk);
            compare(32'(out_en), 32'(0), "out_en after reset");
            compare(32'(in_almost_full), 32'(0), "in_almost_full after reset");
            compare(32'(overflow_err), 32'(0), "overflow_err after reset");
        end

        fd = $fopen("verification/req_buf_trace.txt", "r");
        if (fd == 0)
        begin
            abort_run("cannot open verification/req_buf_trace.txt");
        end
        n = $fscanf(fd, " %c", cmd);
        while (n == 1)
        begin
            case (cmd)
                "#":
                begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1)
                    begin
                        ch = $fgetc(fd);
                    end
                end
                "I":
                begin
                    n = $fscanf(fd, "%h %h", arg_a, arg_b);
                    gap = $urandom % 3;
                    repeat (gap) @(posedge clk);
                    issue_request(t_lane_idx'(arg_a), arg_b);
                end
                "S":
                begin
                    n = $fscanf(fd, "%h", arg_a);
                    set_stall(arg_a[0]);
                end
                "W":
                begin
                    n = $fscanf(fd, "%h", arg_a);
                    repeat (arg_a) @(posedge clk);
                end
                "A":
                begin
                    n = $fscanf(fd, "%h %h", arg_a, arg_b);
                    @(negedge clk);
                    compare(32'(in_almost_full[t_lane_idx'(arg_a)]), 32'(arg_b[0]),
                            $sformatf("in_almost_full of lane %0d", arg_a));
                end
                "R":
                begin
                    n = $fscanf(fd, "%h", arg_a);
                    @(posedge clk);
                    rr_check     = arg_a[0];
                    rr_have_prev = 1'b0;
                end
                "D":
                begin
                    drain_lanes();
                end
                default:
                begin
                    abort_run($sformatf("unknown trace command '%c'", cmd));
                end
            endcase
            n = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);

        // A few spare cycles expose any output nobody asked for
        repeat (4) @(posedge clk);
        compare(32'(out_cnt), 32'(issued_cnt), "output count against issued requests");
        compare(32'(pending_count()), 32'(0), "requests still pending");
        compare(32'(overflow_err), 32'(0), "overflow_err at the end");
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verification/req_buf_trace.txt
# I lane data = issue, S 0|1 = downstream stall, W n = idle n cycles (hex)
# A lane 0|1 = expected in_almost_full, R 0|1 = round-robin check, D = drain
# Mixed traffic, order within each lane
I 0 a0000001
I 1 b1000001
I 2 c2000001
I 3 d3000001
I 0 a0000002
I 0 a0000003
I 2 c2000002
W 5
I 1 b1000002
I 3 d3000002
D
# Stall rises while requests are in flight
I 0 a0000010
I 1 b1000010
I 0 a0000011
I 1 b1000011
S 1
W a
S 0
D
# Fill one lane under stall, 6 then 7 held
S 1
I 2 c2000020
I 2 c2000021
I 2 c2000022
I 2 c2000023
I 2 c2000024
I 2 c2000025
W 4
A 2 0
I 2 c2000026
W 4
A 2 1
S 0
W c
A 2 0
D
# All lanes backlogged then released
S 1
I 0 a0000030
I 1 b1000030
I 2 c2000030
I 3 d3000030
I 0 a0000031
I 1 b1000031
I 2 c2000031
I 3 d3000031
W 6
R 1
S 0
D
R 0

//--- sim.f
src/req_buf_pkg.sv
src/fifo_lutram_base.sv
src/fifo_lutram.sv
src/req_steer.sv
src/req_arbiter.sv
src/req_buf_top.sv
verification/req_buf_props.sv
verification/req_buf_tb.sv

//--- Makefile
# Verilator build and run for the request buffer testbench
# Any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= req_buf_tb
RTL_TOP   ?= req_buf_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
